// File: movegen_cases.txt
// first word is the number of cases, then per case eight rank words (rank 1 first,
// file a in the top digit), the side to play (1 white) and the move count in hex,
// then the 18-bit moves {piece, from, takes, to} in stream order
7
// white knight on a1 and white king on e4 with an empty board around them
d0000000 00000000 00000000 00009000 00000000 00000000 00000000 00000000 1 0a
0b813 0b814 0b815 0b81b 0b81d 0b823 0b824 0b825
2800a 28011
// white rook d4 and bishop c1, own pawns on b2 and d6, black knight f4 and rook e3
00c00000 0e000000 00003000 000b0500 00000000 000e0000 00000000 00000000 1 0b
1b603 1b60b 1b613 1b618 1b619 1b61a 1b61c 1b75d
1b623
2040b 204d4
// white queen a2, king h1, knight b1 with black pawn a3 and bishop b3 in reach
0d000009 ae000000 64000000 00000000 00000000 00000000 00000000 00000000 1 09
11000 11190 11111
08e06 08e0e 08e0f
2820b 28390 28212
// pawns block both rooks, white to play
b000e000 e0000000 00000000 00000000 00000000 00500000 00000006 000e0003 1 03
18001 18002 18003
// same board with black to play
b000e000 e0000000 00000000 00000000 00000000 00500000 00000006 000e0003 0 0c
1ffbb 1fe3c 1fe3d 1fe3e
2d419 2d41b 2d420 2d424 2d430 2d434 2d439 2d5bb
// white has only pawns, the rook of the previous board must be gone
00000000 eeeeeeee 00000000 00000000 00000000 00000000 00000000 00001000 1 00
// white rook, king and bishop boxed in by their own pawns
b9c00000 eeee0000 00000000 00000000 00000000 00000000 00000000 00000001 1 00

// File: movegen_top.f
+incdir+.
movegen_pkg.sv
movegen_board_store.sv
movegen_piece_list.sv
movegen_target_select.sv
movegen_ctrl.sv
movegen_top.sv
movegen_tb_clock.sv
movegen_monitor.sv
movegen_chk.sv
movegen_tb.sv

// File: Bender.yml
package:
  name: movegen

export_include_dirs:
  - .

sources:
  - movegen_pkg.sv
  - movegen_board_store.sv
  - movegen_piece_list.sv
  - movegen_target_select.sv
  - movegen_ctrl.sv
  - movegen_top.sv
  - target: test
    files:
      - movegen_tb_clock.sv
      - movegen_monitor.sv
      - movegen_chk.sv
      - movegen_tb.sv

// File: movegen_tb.sv
`timescale 1ns/100ps
`include "movegen_cfg.svh"

module movegen_tb;

  localparam int timeout_cycles = 2000;

  logic                  clk;
  logic                  arst_n;
  logic                  pos_valid;
  logic                  pos_sop;
  movegen_pkg::sq_code_t pos_code;
  logic                  wtp;
  logic                  start;
  logic                  mv_valid;
  movegen_pkg::move_t    mv;
  logic                  mv_sop;
  logic                  mv_eop;

  // raw words of the cases file and the board and move list of the current case
  logic [31:0]           cases_mem [256];
  movegen_pkg::sq_code_t board_codes [`MOVEGEN_SQUARES];
  movegen_pkg::move_t    exp_moves [`MOVEGEN_SQUARES];
  int                    exp_cnt;
  int                    done_cnt;
  int                    fail_cnt;
  int                    err_cnt;

  movegen_tb_clock u_clock (
    .clk      (clk),
    .o_arst_n (arst_n)
  );

  movegen_top DUT (
    .clk         (clk),
    .i_arst_n    (arst_n),
    .i_pos_valid (pos_valid),
    .i_pos_sop   (pos_sop),
    .i_pos_code  (pos_code),
    .i_wtp       (wtp),
    .i_start     (start),
    .o_valid     (mv_valid),
    .o_move      (mv),
    .o_sop       (mv_sop),
    .o_eop       (mv_eop)
  );

  movegen_monitor u_monitor (
    .clk        (clk),
    .i_valid    (mv_valid),
    .i_move     (mv),
    .i_sop      (mv_sop),
    .i_eop      (mv_eop),
    .i_exp      (exp_moves),
    .i_exp_cnt  (exp_cnt),
    .o_done_cnt (done_cnt),
    .o_fail_cnt (fail_cnt),
    .o_err_cnt  (err_cnt)
  );

  bind movegen_top movegen_chk u_chk (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_start  (i_start),
    .i_valid  (o_valid),
    .i_sop    (o_sop),
    .i_eop    (o_eop)
  );

  // streams the board a1 first, with zero to two idle cycles before each square
  task automatic load_board();
    int gap;
    for (int sq = 0; sq < `MOVEGEN_SQUARES; sq++) begin
      gap = $urandom % 3;
      repeat (gap) begin
        @(posedge clk);
        #2;
        pos_valid = 1'b0;
        pos_sop   = 1'b0;
      end
      @(posedge clk);
      #2;
      pos_valid = 1'b1;
      pos_sop   = (sq == 0);
      pos_code  = board_codes[sq];
    end
    @(posedge clk);
    #2;
    pos_valid = 1'b0;
    pos_sop   = 1'b0;
  endtask

  // wtp is held as a level, only the start is a single cycle
  task automatic pulse_start(input logic side);
    @(posedge clk);
    #2;
    wtp   = side;
    start = 1'b1;
    @(posedge clk);
    #2;
    start = 1'b0;
  endtask

  initial begin : main
    int          ptr;
    int          n_cases;
    int          n_moves;
    int          waited;
    int          timeouts;
    logic        side;
    logic [31:0] rank_word;
    bit          aborted;
    pos_valid = 1'b0;
    pos_sop   = 1'b0;
    pos_code  = '0;
    wtp       = 1'b0;
    start     = 1'b0;
    exp_cnt   = 0;
    timeouts  = 0;
    aborted   = 1'b0;
    for (int i = 0; i < `MOVEGEN_SQUARES; i++) begin
      exp_moves[i] = '0;
    end
    void'($urandom(32'hf726));
    $readmemh("movegen_cases.txt", cases_mem);
    // reset is still unknown at time zero, so only a clean high counts as released
    waited = 0;
    while (arst_n !== 1'b1 && waited < timeout_cycles) begin
      @(posedge clk);
      waited++;
    end
    if (arst_n !== 1'b1) begin
      $display("reset was not released within %0d cycles", timeout_cycles);
      aborted = 1'b1;
    end
    n_cases = int'(cases_mem[0]);
    if (n_cases == 0) begin
      $display("no cases were read from movegen_cases.txt");
      aborted = 1'b1;
    end
    ptr = 1;
    for (int k = 0; k < n_cases && !aborted; k++) begin
      // eight rank words, file a sits in the top hex digit
      for (int r = 0; r < 8; r++) begin
        rank_word = cases_mem[ptr + r];
        for (int f = 0; f < 8; f++) begin
          board_codes[r*8+f] = movegen_pkg::sq_code_t'(rank_word[31-4*f -: 4]);
        end
      end
      side    = cases_mem[ptr + 8][0];
      n_moves = int'(cases_mem[ptr + 9]);
      ptr     = ptr + 10;
      if (n_moves > `MOVEGEN_SQUARES) begin
        $display("case %0d lists %0d moves, more than the testbench holds", k + 1, n_moves);
        aborted = 1'b1;
      end else begin
        for (int j = 0; j < n_moves; j++) begin
          exp_moves[j] = cases_mem[ptr + j][17:0];
        end
        ptr     = ptr + n_moves;
        exp_cnt = n_moves;
        load_board();
        pulse_start(side);
        // the monitor counts one finished case per eop
        waited = 0;
        while (done_cnt < k + 1 && waited < timeout_cycles) begin
          @(posedge clk);
          waited++;
        end
        if (done_cnt < k + 1) begin
          $display("case %0d: no eop within %0d cycles of start", k + 1, timeout_cycles);
          timeouts++;
          aborted = 1'b1;
        end
      end
    end
    $display("%0d of %0d cases done, %0d with errors, %0d errors, %0d timeouts",
             done_cnt, n_cases, fail_cnt, err_cnt, timeouts);
    if (!aborted && fail_cnt == 0 && done_cnt == n_cases && DUT.u_chk.failed !== 1'b1) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: movegen_chk.sv
`timescale 1ns/100ps

module movegen_chk (
  input  logic clk,
  input  logic i_arst_n,
  input  logic i_start,
  input  logic i_valid,
  input  logic i_sop,
  input  logic i_eop
);

  logic in_run;
  logic bad_sop = 1'b0;
  logic bad_start = 1'b0;
  logic bad_eop = 1'b0;
  logic bad_valid = 1'b0;
  logic failed;

  // open from the start pulse until the eop that closes the run
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      in_run <= 1'b0;
    end else if (i_start) begin
      in_run <= 1'b1;
    end else if (i_eop) begin
      in_run <= 1'b0;
    end
  end

  // the first move of a run carries sop, so sop never stands alone
  a_sop_has_valid: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_sop |-> i_valid)
    else begin
      bad_sop = 1'b1;
      $error("o_sop is high while o_valid is low");
    end

  // a second start before the eop would mean two runs share one eop
  a_start_when_idle: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_start |-> !in_run)
    else begin
      bad_start = 1'b1;
      $error("i_start arrived before the previous run gave its eop");
    end

  // together with the check above this allows exactly one eop per start
  a_one_eop: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_eop |-> in_run)
    else begin
      bad_eop = 1'b1;
      $error("o_eop arrived with no run open");
    end

  a_valid_in_run: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_valid |-> in_run)
    else begin
      bad_valid = 1'b1;
      $error("o_valid is high outside a run");
    end

  assign failed = bad_sop | bad_start | bad_eop | bad_valid;

endmodule

// File: movegen_monitor.sv
`timescale 1ns/100ps
`include "movegen_cfg.svh"

module movegen_monitor (
  input  logic               clk,
  input  logic               i_valid,
  input  movegen_pkg::move_t i_move,
  input  logic               i_sop,
  input  logic               i_eop,
  input  movegen_pkg::move_t i_exp [`MOVEGEN_SQUARES],
  input  int                 i_exp_cnt,
  output int                 o_done_cnt,
  output int                 o_fail_cnt,
  output int                 o_err_cnt
);

  // position of the next move within the current run
  int idx;
  int case_errs;

  initial begin
    idx        = 0;
    case_errs  = 0;
    o_done_cnt = 0;
    o_fail_cnt = 0;
    o_err_cnt  = 0;
  end

  // the DUT outputs change on the rising edge, so the falling edge sees them settled
  always @(negedge clk) begin
    if (i_valid === 1'b1) begin
      if (idx >= i_exp_cnt) begin
        $display("case %0d: extra move %h after the %0d expected", o_done_cnt + 1, i_move,
                 i_exp_cnt);
        case_errs++;
      end else begin
        if (i_move !== i_exp[idx]) begin
          $display("ERR t=%0t o_move expected %h got %h", $time, i_exp[idx], i_move);
          case_errs++;
        end
        if (idx == 0 && i_sop !== 1'b1) begin
          $display("case %0d: sop missing on the first move", o_done_cnt + 1);
          case_errs++;
        end
        if (idx != 0 && i_sop !== 1'b0) begin
          $display("case %0d: sop seen again on move %0d", o_done_cnt + 1, idx + 1);
          case_errs++;
        end
        if (idx == i_exp_cnt - 1 && i_eop !== 1'b1) begin
          $display("case %0d: eop missing on the last move", o_done_cnt + 1);
          case_errs++;
        end
      end
      idx++;
    end else if (i_sop === 1'b1) begin
      $display("case %0d: sop seen without a valid move", o_done_cnt + 1);
      case_errs++;
    end
    // eop closes the case, early or late eop shows up as a wrong move count
    if (i_eop === 1'b1) begin
      if (idx != i_exp_cnt) begin
        $display("case %0d: run ended after %0d of %0d moves", o_done_cnt + 1, idx, i_exp_cnt);
        case_errs++;
      end
      if (case_errs == 0) begin
        $display("case %0d: %0d moves, ok", o_done_cnt + 1, idx);
      end else begin
        $display("case %0d: %0d moves, %0d errors", o_done_cnt + 1, idx, case_errs);
        o_fail_cnt++;
      end
      o_err_cnt  += case_errs;
      o_done_cnt++;
      idx        = 0;
      case_errs  = 0;
    end
  end

endmodule

// File: movegen_tb_clock.sv
`timescale 1ns/100ps

module movegen_tb_clock (
  output logic clk,
  output logic o_arst_n
);

  // 40 ns period, the first rising edge comes at 20 ns
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // reset stays low for three rising edges and lets go just after the third
  initial begin
    o_arst_n = 1'b0;
    repeat (3) @(posedge clk);
    #2;
    o_arst_n = 1'b1;
  end

endmodule

// File: movegen_top.sv
`timescale 1ns/100ps

module movegen_top (
  input  logic                  clk,
  input  logic                  i_arst_n,
  input  logic                  i_pos_valid,
  input  logic                  i_pos_sop,
  input  movegen_pkg::sq_code_t i_pos_code,
  input  logic                  i_wtp,
  input  logic                  i_start,
  output logic                  o_valid,
  output movegen_pkg::move_t    o_move,
  output logic                  o_sop,
  output logic                  o_eop
);

  movegen_pkg::board_t       board;
  movegen_pkg::square_u      load_sq;
  movegen_pkg::square_u      lookup_sq;
  movegen_pkg::sq_code_t     lookup_code;
  movegen_pkg::stack_entry_t head;
  movegen_pkg::square_u      cand_to;
  logic                      more;
  logic                      cand_valid;
  logic                      piece_done;
  logic                      pop;
  logic                      start;

  // the serial load feeds both the board and the piece stacks in parallel
  movegen_board_store u_board_store (
    .clk           (clk),
    .i_arst_n      (i_arst_n),
    .i_pos_valid   (i_pos_valid),
    .i_pos_sop     (i_pos_sop),
    .i_pos_code    (i_pos_code),
    .i_lookup_sq   (lookup_sq),
    .o_board       (board),
    .o_load_sq     (load_sq),
    .o_lookup_code (lookup_code)
  );

  movegen_piece_list u_piece_list (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_pos_valid (i_pos_valid),
    .i_pos_sop   (i_pos_sop),
    .i_pos_code  (i_pos_code),
    .i_load_sq   (load_sq),
    .i_wtp       (i_wtp),
    .i_start     (start),
    .i_pop       (pop),
    .o_head      (head),
    .o_more      (more)
  );

  movegen_target_select u_target_select (
    .clk          (clk),
    .i_arst_n     (i_arst_n),
    .i_start      (start),
    .i_board      (board),
    .i_head       (head),
    .i_pop        (pop),
    .o_cand_valid (cand_valid),
    .o_cand_to    (cand_to),
    .o_piece_done (piece_done)
  );

  movegen_ctrl u_ctrl (
    .clk          (clk),
    .i_arst_n     (i_arst_n),
    .i_start      (i_start),
    .i_head       (head),
    .i_more       (more),
    .i_cand_valid (cand_valid),
    .i_cand_to    (cand_to),
    .i_piece_done (piece_done),
    .i_takes      (lookup_code.piece),
    .o_pop        (pop),
    .o_start      (start),
    .o_lookup_sq  (lookup_sq),
    .o_valid      (o_valid),
    .o_move       (o_move),
    .o_sop        (o_sop),
    .o_eop        (o_eop)
  );

endmodule

// File: movegen_ctrl.sv
`timescale 1ns/100ps
`include "movegen_cfg.svh"

module movegen_ctrl (
  input  logic                      clk,
  input  logic                      i_arst_n,
  input  logic                      i_start,
  input  movegen_pkg::stack_entry_t i_head,
  input  logic                      i_more,
  input  logic                      i_cand_valid,
  input  movegen_pkg::square_u      i_cand_to,
  input  logic                      i_piece_done,
  input  movegen_pkg::piece_e       i_takes,
  output logic                      o_pop,
  output logic                      o_start,
  output movegen_pkg::square_u      o_lookup_sq,
  output logic                      o_valid,
  output movegen_pkg::move_t        o_move,
  output logic                      o_sop,
  output logic                      o_eop
);

  localparam int cnt_w = $clog2(`MOVEGEN_STACK_DEPTH);

  logic               run;
  logic [cnt_w-1:0]   piece_cnt;
  logic               cand;
  logic               last;
  logic               buf_valid;
  logic               buf_sop;
  logic               done_sop;
  movegen_pkg::move_t cand_move;
  movegen_pkg::move_t buf_move;

  // a start that lands during a run is ignored
  assign o_start     = i_start & ~run;
  assign o_lookup_sq = i_cand_to;
  assign cand        = run & i_cand_valid;

  // the run ends on the last piece, the counter bounds it at a full stack
  assign last = run & i_piece_done &
                (~i_more | (piece_cnt == cnt_w'(`MOVEGEN_STACK_DEPTH - 1)));

  always_comb begin
    cand_move.piece = i_head.piece;
    cand_move.from  = i_head.sq;
    cand_move.takes = i_takes;
    cand_move.to    = i_cand_to;
  end

  // whether a move is the final one is only known once the next candidate
  // or the last piece done shows up, so each move waits one step in the buffer
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      run       <= 1'b0;
      piece_cnt <= '0;
      o_pop     <= 1'b0;
      buf_valid <= 1'b0;
      buf_sop   <= 1'b0;
      done_sop  <= 1'b0;
      o_valid   <= 1'b0;
      o_sop     <= 1'b0;
      o_eop     <= 1'b0;
    end else begin
      if (o_start) begin
        run       <= 1'b1;
        piece_cnt <= '0;
      end else begin
        if (last) begin
          run <= 1'b0;
        end
        if (run && i_piece_done) begin
          piece_cnt <= piece_cnt + 1'b1;
        end
      end
      // pop lands one cycle after piece done, the target select idles meanwhile
      o_pop <= run & i_piece_done;
      if (cand) begin
        buf_sop <= ~done_sop;
      end
      if (cand || last) begin
        buf_valid <= cand;
        done_sop  <= (done_sop | cand) & ~last;
      end
      o_valid <= buf_valid & (cand | last);
      o_sop   <= buf_valid & buf_sop & (cand | last);
      o_eop   <= last;
    end
  end

  always_ff @(posedge clk) begin
    if (cand) begin
      buf_move <= cand_move;
    end
    o_move <= buf_move;
  end

endmodule

// File: movegen_target_select.sv
`timescale 1ns/100ps
`include "movegen_cfg.svh"

module movegen_target_select (
  input  logic                      clk,
  input  logic                      i_arst_n,
  input  logic                      i_start,
  input  movegen_pkg::board_t       i_board,
  input  movegen_pkg::stack_entry_t i_head,
  input  logic                      i_pop,
  output logic                      o_cand_valid,
  output movegen_pkg::square_u      o_cand_to,
  output logic                      o_piece_done
);

  localparam int req_w = `MOVEGEN_SQUARES + 1;

  // king steps clockwise from north, even entries are orthogonal and odd are diagonal
  localparam int king_dr [8] = '{1, 1, 0, -1, -1, -1, 0, 1};
  localparam int king_df [8] = '{0, 1, 1, 1, 0, -1, -1, -1};
  localparam int knight_dr [8] = '{2, 1, -1, -2, -2, -1, 1, 2};
  localparam int knight_df [8] = '{1, 2, 2, 1, -1, -2, -2, -1};

  logic [`MOVEGEN_SQUARES-1:0] reach;
  logic [`MOVEGEN_SQUARES-1:0] own;
  logic [req_w-1:0]            req;
  logic [req_w-1:0]            above;
  logic [req_w-1:0]            grant;
  logic [req_w-1:0]            base_q;
  logic                        mover_white;
  logic                        leaps_king;
  logic                        leaps_knight;
  logic                        slides_orth;
  logic                        slides_diag;

  // the head entry carries no colour, the board square under it does
  assign mover_white  = i_board[i_head.sq.idx].white;
  assign leaps_king   = i_head.piece == movegen_pkg::pc_king;
  assign leaps_knight = i_head.piece == movegen_pkg::pc_knight;
  assign slides_orth  = (i_head.piece == movegen_pkg::pc_rook) ||
                        (i_head.piece == movegen_pkg::pc_queen);
  assign slides_diag  = (i_head.piece == movegen_pkg::pc_bishop) ||
                        (i_head.piece == movegen_pkg::pc_queen);

  // every square the head piece can reach, own pieces are removed further down
  // a ray marks the first occupied square it meets and then stops
  always_comb begin : gen_reach
    int   r;
    int   f;
    int   nr;
    int   nf;
    int   d;
    int   s;
    logic open;
    reach = '0;
    r = int'(i_head.sq.rf.rank);
    f = int'(i_head.sq.rf.file);
    for (d = 0; d < 8; d++) begin
      nr = r + knight_dr[d];
      nf = f + knight_df[d];
      if (leaps_knight && nr >= 0 && nr < 8 && nf >= 0 && nf < 8) begin
        reach[nr*8+nf] = 1'b1;
      end
      nr = r + king_dr[d];
      nf = f + king_df[d];
      if (leaps_king && nr >= 0 && nr < 8 && nf >= 0 && nf < 8) begin
        reach[nr*8+nf] = 1'b1;
      end
      open = d[0] ? slides_diag : slides_orth;
      for (s = 1; s < 8; s++) begin
        nr = r + king_dr[d] * s;
        nf = f + king_df[d] * s;
        if (open && nr >= 0 && nr < 8 && nf >= 0 && nf < 8) begin
          reach[nr*8+nf] = 1'b1;
          if (i_board[nr*8+nf].piece != movegen_pkg::pc_none) begin
            open = 1'b0;
          end
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `MOVEGEN_SQUARES; i++) begin
      own[i] = (i_board[i].piece != movegen_pkg::pc_none) && (i_board[i].white == mover_white);
    end
  end

  // the top request never drops, so once the destinations run out it reports piece done
  assign req = {1'b1, reach & ~own & {`MOVEGEN_SQUARES{i_head.full}}};

  // keep requests at or above the base and take the lowest one
  // a zero base grants nothing, which idles the cycle before the pop lands
  assign above = req & ~(base_q - req_w'(1));
  assign grant = above & (~above + req_w'(1));

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      base_q <= req_w'(1);
    end else if (i_start || i_pop) begin
      base_q <= req_w'(1);
    end else begin
      base_q <= grant << 1;
    end
  end

  always_comb begin : encode
    o_cand_to.idx = 6'd0;
    for (int i = 0; i < `MOVEGEN_SQUARES; i++) begin
      if (grant[i]) begin
        o_cand_to.idx = o_cand_to.idx | 6'(i);
      end
    end
  end

  assign o_cand_valid = |grant[`MOVEGEN_SQUARES-1:0];
  assign o_piece_done = grant[`MOVEGEN_SQUARES];

endmodule

// File: movegen_piece_list.sv
`timescale 1ns/100ps
`include "movegen_cfg.svh"

module movegen_piece_list (
  input  logic                      clk,
  input  logic                      i_arst_n,
  input  logic                      i_pos_valid,
  input  logic                      i_pos_sop,
  input  movegen_pkg::sq_code_t     i_pos_code,
  input  movegen_pkg::square_u      i_load_sq,
  input  logic                      i_wtp,
  input  logic                      i_start,
  input  logic                      i_pop,
  output movegen_pkg::stack_entry_t o_head,
  output logic                      o_more
);

  // side_q[1] holds white pieces and side_q[0] black, slot 0 is the newest
  movegen_pkg::stack_entry_t side_q [2][`MOVEGEN_STACK_DEPTH];
  movegen_pkg::stack_entry_t move_q [`MOVEGEN_STACK_DEPTH];
  movegen_pkg::stack_entry_t push_entry;
  logic [1:0]                push;
  logic                      is_mover;

  // pawns only matter as blockers on the board, they never get a slot
  assign is_mover = (i_pos_code.piece != movegen_pkg::pc_none) &&
                    (i_pos_code.piece != movegen_pkg::pc_pawn);
  assign push[1]  = i_pos_valid & is_mover & i_pos_code.white;
  assign push[0]  = i_pos_valid & is_mover & ~i_pos_code.white;

  always_comb begin
    push_entry.full  = 1'b1;
    push_entry.piece = i_pos_code.piece;
    push_entry.sq    = i_load_sq;
  end

  // a push shifts every slot down by one, sop empties both stacks first
  // and a piece standing on a1 still goes into the fresh stack
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int c = 0; c < 2; c++) begin
        for (int i = 0; i < `MOVEGEN_STACK_DEPTH; i++) begin
          side_q[c][i] <= '0;
        end
      end
    end else begin
      for (int c = 0; c < 2; c++) begin
        if (i_pos_valid && i_pos_sop) begin
          for (int i = 0; i < `MOVEGEN_STACK_DEPTH; i++) begin
            side_q[c][i] <= '0;
          end
          if (push[c]) begin
            side_q[c][0] <= push_entry;
          end
        end else if (push[c]) begin
          side_q[c][0] <= push_entry;
          for (int i = 1; i < `MOVEGEN_STACK_DEPTH; i++) begin
            side_q[c][i] <= side_q[c][i-1];
          end
        end
      end
    end
  end

  // the move stack copies the side to play in one cycle and then drains
  // upwards one piece per pop, the colour stacks are left untouched
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < `MOVEGEN_STACK_DEPTH; i++) begin
        move_q[i] <= '0;
      end
    end else if (i_start) begin
      for (int i = 0; i < `MOVEGEN_STACK_DEPTH; i++) begin
        move_q[i] <= side_q[i_wtp][i];
      end
    end else if (i_pop) begin
      for (int i = 0; i < `MOVEGEN_STACK_DEPTH - 1; i++) begin
        move_q[i] <= move_q[i+1];
      end
      move_q[`MOVEGEN_STACK_DEPTH-1] <= '0;
    end
  end

  assign o_head = move_q[0];
  // another piece waits behind the head
  assign o_more = move_q[1].full;

endmodule

// File: movegen_board_store.sv
`timescale 1ns/100ps
`include "movegen_cfg.svh"

module movegen_board_store (
  input  logic                  clk,
  input  logic                  i_arst_n,
  input  logic                  i_pos_valid,
  input  logic                  i_pos_sop,
  input  movegen_pkg::sq_code_t i_pos_code,
  input  movegen_pkg::square_u  i_lookup_sq,
  output movegen_pkg::board_t   o_board,
  output movegen_pkg::square_u  o_load_sq,
  output movegen_pkg::sq_code_t o_lookup_code
);

  movegen_pkg::square_u next_sq;
  movegen_pkg::square_u load_sq;
  movegen_pkg::board_t  board_q;

  // sop always lands on a1, whatever the counter was left at
  always_comb begin
    load_sq = next_sq;
    if (i_pos_sop) begin
      load_sq.idx = 6'd0;
    end
  end

  // the counter only steps on valid cycles so gaps in the load are harmless
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      next_sq.idx <= 6'd0;
    end else if (i_pos_valid) begin
      if (load_sq.idx == 6'(`MOVEGEN_SQUARES - 1)) begin
        next_sq.idx <= 6'd0;
      end else begin
        next_sq.idx <= load_sq.idx + 6'd1;
      end
    end
  end

  // every square is rewritten on each load, so the old board never leaks through
  always_ff @(posedge clk) begin
    if (i_pos_valid) begin
      board_q[load_sq.idx] <= i_pos_code;
    end
  end

  assign o_board   = board_q;
  assign o_load_sq = load_sq;

  // the candidate destination looked up here gives the captured piece
  assign o_lookup_code = board_q[i_lookup_sq.idx];

endmodule

// File: movegen_pkg.sv
`include "movegen_cfg.svh"

package movegen_pkg;

  // piece numbers, shared by the load codes and the move word
  typedef enum logic [`MOVEGEN_CODE_W-2:0] {
    pc_none   = 3'd0,
    pc_king   = 3'd1,
    pc_queen  = 3'd2,
    pc_rook   = 3'd3,
    pc_bishop = 3'd4,
    pc_knight = 3'd5,
    pc_pawn   = 3'd6
  } piece_e;

  // one square of the serial load, piece none means the square is empty
  typedef struct packed {
    logic   white;
    piece_e piece;
  } sq_code_t;

  // the same six bits read flat or as rank/file, the file sits in the low bits
  typedef union packed {
    logic [5:0] idx;
    struct packed {
      logic [2:0] rank;
      logic [2:0] file;
    } rf;
  } square_u;

  // a piece stack slot, full is low on an unused slot
  typedef struct packed {
    logic    full;
    piece_e  piece;
    square_u sq;
  } stack_entry_t;

  // 18-bit move word, takes is none on a quiet move
  typedef struct packed {
    piece_e  piece;
    square_u from;
    piece_e  takes;
    square_u to;
  } move_t;

  typedef sq_code_t [`MOVEGEN_SQUARES-1:0] board_t;

endpackage

// File: movegen_cfg.svh
`ifndef MOVEGEN_CFG_SVH
`define MOVEGEN_CFG_SVH

// the board is a fixed 8x8 grid, a1 is square 0 and h8 is square 63
`define MOVEGEN_SQUARES 64

// one slot for every non-pawn piece a colour could ever hold
`define MOVEGEN_STACK_DEPTH 16

// a square code is a colour flag above a 3-bit piece number
`define MOVEGEN_CODE_W 4

`endif
